// File: rtl/csr_pkg.sv
package csr_pkg;

  // one CSR word; every counter is two words wide.
  localparam int xlen = 32;

  // user counter addresses, low word then high word.
  localparam logic [xlen-1:0] csr_cycle    = 32'h0000_0C00;
  localparam logic [xlen-1:0] csr_cycleh   = 32'h0000_0C80;

  localparam logic [xlen-1:0] csr_time     = 32'h0000_0C01;
  localparam logic [xlen-1:0] csr_timeh    = 32'h0000_0C81;

  localparam logic [xlen-1:0] csr_instret  = 32'h0000_0C02;
  localparam logic [xlen-1:0] csr_instreth = 32'h0000_0C82;

endpackage

// File: rtl/csr_counter64.sv
`timescale 1ns/1ps

module csr_counter64 import csr_pkg::*; (
  input  logic              clk,
  input  logic              rst,
  input  logic              inc,
  input  logic              lo_we,
  input  logic              hi_we,
  input  logic [xlen-1:0]   wr_data,
  input  logic [xlen-1:0]   wr_mask,
  output logic [2*xlen-1:0] count
);

  logic [xlen-1:0]   count_lo;
  logic [xlen-1:0]   count_hi;
  logic [xlen-1:0]   merged_lo;
  logic [xlen-1:0]   merged_hi;
  logic [2*xlen-1:0] count_next;

  assign count_lo = count[xlen-1:0];
  assign count_hi = count[2*xlen-1:xlen];

  // mask bits at one take the new data, the rest keep the old value.
  assign merged_lo = (count_lo & ~wr_mask) | (wr_data & wr_mask);
  assign merged_hi = (count_hi & ~wr_mask) | (wr_data & wr_mask);

  always_comb begin
    count_next = count;
    if (lo_we || hi_we) begin // a write cycle suppresses the increment.
      if (lo_we) begin
        count_next[xlen-1:0] = merged_lo;
      end
      if (hi_we) begin
        count_next[2*xlen-1:xlen] = merged_hi;
      end
    end else if (inc) begin
      count_next = count + (2*xlen)'(1); // carry runs into the high word.
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      count <= '0;
    end else begin
      count <= count_next;
    end
  end

endmodule

// File: rtl/time_prescaler.sv
`timescale 1ns/1ps

module time_prescaler #(
  parameter int TICK_DIV = 50000
) (
  input  logic clk,
  input  logic rst,
  output logic tick
);

  localparam int cnt_w = (TICK_DIV > 1) ? $clog2(TICK_DIV) : 1;
  localparam logic [cnt_w-1:0] last_count = cnt_w'(TICK_DIV - 1);

  logic [cnt_w-1:0] div_count;

  // tick marks the last clock of each period.
  assign tick = (div_count == last_count);

  always_ff @(posedge clk) begin
    if (rst) begin
      div_count <= '0;
    end else if (tick) begin
      div_count <= '0; // wrap back for the next period.
    end else begin
      div_count <= div_count + cnt_w'(1);
    end
  end

endmodule

// File: rtl/csr_access.sv
`timescale 1ns/1ps

module csr_access import csr_pkg::*; (
  input  logic              clk,
  input  logic              rst,
  input  logic              csr_req,
  input  logic              csr_write,
  input  logic [xlen-1:0]   csr_addr,
  input  logic [xlen-1:0]   csr_mask,
  input  logic [xlen-1:0]   csr_data_wr,
  input  logic [2*xlen-1:0] cycle_count,
  input  logic [2*xlen-1:0] time_count,
  input  logic [2*xlen-1:0] instret_count,
  output logic              cycle_lo_we,
  output logic              cycle_hi_we,
  output logic              time_lo_we,
  output logic              time_hi_we,
  output logic              instret_lo_we,
  output logic              instret_hi_we,
  output logic [xlen-1:0]   wr_data,
  output logic [xlen-1:0]   wr_mask,
  output logic              csr_ack,
  output logic [xlen-1:0]   csr_data_rd
);

  logic            wr_hit;
  logic            rd_hit;
  logic [xlen-1:0] rd_word;

  assign wr_hit = csr_req & csr_write;
  assign rd_hit = csr_req & ~csr_write;

  // strobes act in the request cycle so the word updates at the sampling edge.
  assign cycle_lo_we   = wr_hit && (csr_addr == csr_cycle);
  assign cycle_hi_we   = wr_hit && (csr_addr == csr_cycleh);
  assign time_lo_we    = wr_hit && (csr_addr == csr_time);
  assign time_hi_we    = wr_hit && (csr_addr == csr_timeh);
  assign instret_lo_we = wr_hit && (csr_addr == csr_instret);
  assign instret_hi_we = wr_hit && (csr_addr == csr_instreth);

  assign wr_data = csr_data_wr;
  assign wr_mask = csr_mask;

  always_comb begin
    case (csr_addr)
      csr_cycle: begin
        rd_word = cycle_count[xlen-1:0];
      end
      csr_cycleh: begin
        rd_word = cycle_count[2*xlen-1:xlen];
      end
      csr_time: begin
        rd_word = time_count[xlen-1:0];
      end
      csr_timeh: begin
        rd_word = time_count[2*xlen-1:xlen];
      end
      csr_instret: begin
        rd_word = instret_count[xlen-1:0];
      end
      csr_instreth: begin
        rd_word = instret_count[2*xlen-1:xlen];
      end
      default: begin
        rd_word = '0; // unknown addresses read as zero.
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      csr_ack     <= 1'b0;
      csr_data_rd <= '0;
    end else begin
      csr_ack     <= csr_req; // every request is acknowledged one clock later.
      csr_data_rd <= rd_hit ? rd_word : '0; // data is only valid with a read ack.
    end
  end

endmodule

// File: rtl/riscv_csr.sv
`timescale 1ns/1ps

module riscv_csr import csr_pkg::*; #(
  parameter int TICK_DIV = 50000
) (
  input  logic            clk,
  input  logic            rst,
  input  logic            alu_vld,
  input  logic            alu_retired,
  input  logic            csr_req,
  output logic            csr_ack,
  input  logic            csr_write,
  input  logic [xlen-1:0] csr_addr,
  input  logic [xlen-1:0] csr_mask,
  input  logic [xlen-1:0] csr_data_wr,
  output logic [xlen-1:0] csr_data_rd
);

  logic              cycle_lo_we;
  logic              cycle_hi_we;
  logic              time_lo_we;
  logic              time_hi_we;
  logic              instret_lo_we;
  logic              instret_hi_we;
  logic [xlen-1:0]   wr_data;
  logic [xlen-1:0]   wr_mask;
  logic [2*xlen-1:0] cycle_count;
  logic [2*xlen-1:0] time_count;
  logic [2*xlen-1:0] instret_count;
  logic              tick;
  logic              retire;

  assign retire = alu_vld & alu_retired; // only valid, retired instructions count.

  csr_access access (
    .clk           (clk),
    .rst           (rst),
    .csr_req       (csr_req),
    .csr_write     (csr_write),
    .csr_addr      (csr_addr),
    .csr_mask      (csr_mask),
    .csr_data_wr   (csr_data_wr),
    .cycle_count   (cycle_count),
    .time_count    (time_count),
    .instret_count (instret_count),
    .cycle_lo_we   (cycle_lo_we),
    .cycle_hi_we   (cycle_hi_we),
    .time_lo_we    (time_lo_we),
    .time_hi_we    (time_hi_we),
    .instret_lo_we (instret_lo_we),
    .instret_hi_we (instret_hi_we),
    .wr_data       (wr_data),
    .wr_mask       (wr_mask),
    .csr_ack       (csr_ack),
    .csr_data_rd   (csr_data_rd)
  );

  time_prescaler #(
    .TICK_DIV (TICK_DIV)
  ) prescaler (
    .clk  (clk),
    .rst  (rst),
    .tick (tick)
  );

  csr_counter64 cycle_counter (
    .clk     (clk),
    .rst     (rst),
    .inc     (1'b1), // cycle runs on every clock.
    .lo_we   (cycle_lo_we),
    .hi_we   (cycle_hi_we),
    .wr_data (wr_data),
    .wr_mask (wr_mask),
    .count   (cycle_count)
  );

  csr_counter64 time_counter (
    .clk     (clk),
    .rst     (rst),
    .inc     (tick),
    .lo_we   (time_lo_we),
    .hi_we   (time_hi_we),
    .wr_data (wr_data),
    .wr_mask (wr_mask),
    .count   (time_count)
  );

  csr_counter64 instret_counter (
    .clk     (clk),
    .rst     (rst),
    .inc     (retire),
    .lo_we   (instret_lo_we),
    .hi_we   (instret_hi_we),
    .wr_data (wr_data),
    .wr_mask (wr_mask),
    .count   (instret_count)
  );

endmodule

// File: verification/riscv_csr_checker.sv
`timescale 1ns/1ps

module riscv_csr_checker import csr_pkg::*; (
  input logic            clk,
  input logic            rst,
  input logic            csr_req,
  input logic            csr_ack,
  input logic [xlen-1:0] csr_data_rd,
  input logic            tick
);

  // every request cycle is answered on the next clock.
  ack_after_req: assert property (@(posedge clk) disable iff (rst) csr_req |=> csr_ack)
    else $error("csr_ack did not follow a request by one cycle");

  no_ack_without_req: assert property (@(posedge clk) disable iff (rst) !csr_req |=> !csr_ack)
    else $error("csr_ack rose without a request in the cycle before");

  ack_low_after_reset: assert property (@(posedge clk) rst |=> !csr_ack)
    else $error("csr_ack was high in the cycle after reset");

  // the read bus is only driven while an ack is out.
  data_zero_idle: assert property (@(posedge clk) disable iff (rst) !csr_ack |-> csr_data_rd == '0)
    else $error("csr_data_rd was nonzero without an ack");

  tick_single: assert property (@(posedge clk) disable iff (rst) tick |=> !tick)
    else $error("prescaler tick was high on two cycles in a row");

endmodule

// File: verification/riscv_csr_tb.sv
`timescale 1ns/1ps

module riscv_csr_tb import csr_pkg::*; ();

  localparam int tick_div    = 7;
  localparam int drain_limit = 10;
  localparam logic [xlen-1:0] counter_addrs [6] = '{
    csr_cycle, csr_cycleh, csr_time, csr_timeh, csr_instret, csr_instreth
  };

  logic            clk = 1'b0;
  logic            rst;
  logic            alu_vld;
  logic            alu_retired;
  logic            csr_req;
  logic            csr_ack;
  logic            csr_write;
  logic [xlen-1:0] csr_addr;
  logic [xlen-1:0] csr_mask;
  logic [xlen-1:0] csr_data_wr;
  logic [xlen-1:0] csr_data_rd;

  logic [2*xlen-1:0] m_cycle;
  logic [2*xlen-1:0] m_time;
  logic [2*xlen-1:0] m_instret;
  int                m_div;
  bit                active;
  bit                rand_alu;
  logic [xlen-1:0]   exp_q [$];
  logic [xlen-1:0]   addr_q [$];
  int                data_errors;
  int                ack_errors;
  int                timeout_errors;

  riscv_csr #(
    .TICK_DIV (tick_div)
  ) riscv_csr_inst (
    .clk         (clk),
    .rst         (rst),
    .alu_vld     (alu_vld),
    .alu_retired (alu_retired),
    .csr_req     (csr_req),
    .csr_ack     (csr_ack),
    .csr_write   (csr_write),
    .csr_addr    (csr_addr),
    .csr_mask    (csr_mask),
    .csr_data_wr (csr_data_wr),
    .csr_data_rd (csr_data_rd)
  );

  bind riscv_csr riscv_csr_checker checker_inst (
    .clk         (clk),
    .rst         (rst),
    .csr_req     (csr_req),
    .csr_ack     (csr_ack),
    .csr_data_rd (csr_data_rd),
    .tick        (tick)
  );

  always #20 clk = ~clk;

  // bit by bit, a set mask bit picks the new value.
  function automatic logic [xlen-1:0] merge_word(input logic [xlen-1:0] old_word,
                                                 input logic [xlen-1:0] new_word,
                                                 input logic [xlen-1:0] mask);
    logic [xlen-1:0] result;
    for (int i = 0; i < xlen; i++) begin
      result[i] = mask[i] ? new_word[i] : old_word[i];
    end
    return result;
  endfunction

  function automatic logic [2*xlen-1:0] next_count(input logic [2*xlen-1:0] cur,
                                                   input logic inc,
                                                   input logic [xlen-1:0] lo_addr,
                                                   input logic [xlen-1:0] hi_addr);
    logic              wr;
    logic [2*xlen-1:0] nxt;
    wr  = csr_req && csr_write;
    nxt = cur;
    if (wr && csr_addr == lo_addr) begin
      nxt[xlen-1:0] = merge_word(cur[xlen-1:0], csr_data_wr, csr_mask);
    end else if (wr && csr_addr == hi_addr) begin
      nxt[2*xlen-1:xlen] = merge_word(cur[2*xlen-1:xlen], csr_data_wr, csr_mask);
    end else if (inc) begin
      nxt = cur + 64'd1;
    end
    return nxt;
  endfunction

  function automatic logic [xlen-1:0] expected_word(input logic [xlen-1:0] addr);
    case (addr)
      csr_cycle:    return m_cycle[xlen-1:0];
      csr_cycleh:   return m_cycle[2*xlen-1:xlen];
      csr_time:     return m_time[xlen-1:0];
      csr_timeh:    return m_time[2*xlen-1:xlen];
      csr_instret:  return m_instret[xlen-1:0];
      csr_instreth: return m_instret[2*xlen-1:xlen];
      default:      return '0;
    endcase
  endfunction

  always @(posedge clk) begin
    active = !rst;
    if (rst) begin
      m_cycle   = '0;
      m_time    = '0;
      m_instret = '0;
      m_div     = 0;
    end else begin
      if (csr_req) begin // the value seen during the request cycle.
        exp_q.push_back(csr_write ? '0 : expected_word(csr_addr));
        addr_q.push_back(csr_addr);
      end
      m_cycle   = next_count(m_cycle, 1'b1, csr_cycle, csr_cycleh);
      m_time    = next_count(m_time, m_div == tick_div - 1, csr_time, csr_timeh);
      m_instret = next_count(m_instret, alu_vld && alu_retired, csr_instret, csr_instreth);
      m_div     = (m_div == tick_div - 1) ? 0 : m_div + 1;
    end
  end

  always @(negedge clk) begin
    logic [xlen-1:0] exp_word;
    logic [xlen-1:0] exp_addr;
    if (active) begin
      assert (csr_ack == (exp_q.size() != 0)) else begin
        ack_errors++;
        $display("ERROR %0t: csr_ack is %b with %0d requests outstanding",
                 $time, csr_ack, exp_q.size());
      end
      if (csr_ack && exp_q.size() != 0) begin
        exp_word = exp_q.pop_front();
        exp_addr = addr_q.pop_front();
        assert (csr_data_rd == exp_word) else begin
          data_errors++;
          $display("ERROR %0t: ack for address %h returned %h, expected %h",
                   $time, exp_addr, csr_data_rd, exp_word);
        end
      end else begin
        assert (csr_data_rd == '0) else begin
          data_errors++;
          $display("ERROR %0t: csr_data_rd is %h outside an ack", $time, csr_data_rd);
        end
      end
    end
  end

  task automatic step();
    @(negedge clk);
    if (rand_alu) begin
      alu_vld     = ($urandom % 2) == 1;
      alu_retired = ($urandom % 2) == 1;
    end
  endtask

  task automatic issue_request(input logic write, input logic [xlen-1:0] addr,
                               input logic [xlen-1:0] data, input logic [xlen-1:0] mask);
    step();
    csr_req     = 1'b1;
    csr_write   = write;
    csr_addr    = addr;
    csr_data_wr = data;
    csr_mask    = mask;
  endtask

  task automatic read_word(input logic [xlen-1:0] addr);
    issue_request(1'b0, addr, '0, '0);
  endtask

  task automatic write_word(input logic [xlen-1:0] addr, input logic [xlen-1:0] data,
                            input logic [xlen-1:0] mask);
    issue_request(1'b1, addr, data, mask);
  endtask

  task automatic idle();
    step();
    csr_req   = 1'b0;
    csr_write = 1'b0;
  endtask

  task automatic read_all();
    for (int i = 0; i < 6; i++) begin
      read_word(counter_addrs[i]);
    end
  endtask

  task automatic drain_acks();
    int waited;
    idle();
    waited = 0;
    do begin
      @(posedge clk);
      waited++;
    end while (exp_q.size() != 0 && waited < drain_limit);
    if (exp_q.size() != 0) begin
      timeout_errors++;
      $display("timeout: %0d requests got no ack within %0d cycles", exp_q.size(), drain_limit);
    end
  endtask

  initial begin
    void'($urandom(32'ha66d_21c7));
    rst            = 1'b1;
    alu_vld        = 1'b0;
    alu_retired    = 1'b0;
    csr_req        = 1'b0;
    csr_write      = 1'b0;
    csr_addr       = '0;
    csr_mask       = '0;
    csr_data_wr    = '0;
    rand_alu       = 1'b0;
    data_errors    = 0;
    ack_errors     = 0;
    timeout_errors = 0;
    repeat (5) @(negedge clk);
    rst = 1'b0;

    read_all();
    drain_acks();
    repeat (8) begin
      read_word(csr_cycle);
      read_word(csr_cycleh);
    end
    drain_acks();
    repeat (50) begin // about a hundred clocks, so time steps many times.
      read_word(csr_time);
      read_word(csr_timeh);
    end
    drain_acks();

    rand_alu = 1'b1;
    repeat (60) begin
      case ($urandom % 3)
        0: read_word(csr_instret);
        1: read_word(csr_instreth);
        default: idle();
      endcase
    end
    drain_acks();

    repeat (3) begin
      for (int i = 0; i < 6; i++) begin
        write_word(counter_addrs[i], $urandom, $urandom);
        read_word(counter_addrs[i]);
      end
    end
    write_word(csr_cycle, 32'hffff_fffc, 32'hffff_ffff); // carry lands a few clocks later.
    repeat (6) begin
      read_word(csr_cycle);
      read_word(csr_cycleh);
    end
    write_word(csr_time, 32'hffff_ffff, 32'hffff_ffff);
    repeat (10) read_word(csr_timeh);
    write_word(csr_instret, 32'hffff_ffff, 32'hffff_ffff);
    repeat (30) read_word(csr_instreth);
    drain_acks();
    rand_alu = 1'b0;

    read_word(32'h0000_0c03);
    repeat (8) begin
      read_word(32'h0001_0000 | $urandom);
      write_word(32'h0001_0000 | $urandom, $urandom, 32'hffff_ffff);
    end
    read_all();
    drain_acks();

    $display("errors: data %0d, ack %0d, timeout %0d", data_errors, ack_errors, timeout_errors);
    if (data_errors + ack_errors + timeout_errors == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

// File: sources.f
rtl/csr_pkg.sv
rtl/csr_counter64.sv
rtl/time_prescaler.sv
rtl/csr_access.sv
rtl/riscv_csr.sv
verification/riscv_csr_checker.sv
verification/riscv_csr_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build the testbench with Verilator, run it, and look for the pass line in the log.
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert --top-module riscv_csr_tb -f sources.f \
  -o riscv_csr_sim > build.log 2>&1 &&
  ./obj_dir/riscv_csr_sim > sim.log 2>&1 ||
  { echo "build or simulation failed, see build.log and sim.log"; exit 1; }

grep -q "\*\*\* TEST PASSED \*\*\*" sim.log &&
  echo "simulation passed" ||
  { echo "simulation failed, see sim.log"; exit 1; }
